/* src.f */
+incdir+.
polara_pkg.sv
soc_bus_demux.sv
l2_mem.sv
ctrl_registers.sv
polara_soc.sv
tb_polara_soc.sv

/* Bender.yml */
package:
  name: polara_soc

export_include_dirs:
  - .

sources:
  - files:
      - polara_pkg.sv
      - soc_bus_demux.sv
      - l2_mem.sv
      - ctrl_registers.sv
      - polara_soc.sv
  - target: simulation
    files:
      - tb_polara_soc.sv

/* tb_polara_soc.sv */
/*
 * Testbench for the memory subsystem. L2 checks only read words that were
 * fully written first, since the L2 has no reset.
 */
`timescale 1ns/100ps
`include "polara_cfg.svh"

module tb_polara_soc import polara_pkg::*;;

    localparam int unsigned N_L2        = 32;
    localparam int unsigned L2_WORDS    = `POLARA_L2_BYTES / 8;
    localparam int unsigned N_XFERS     = 3 * N_L2 + 6 + 10;
    localparam int unsigned WATCHDOG_NS = (8 + N_XFERS * 20) * 10;

    logic                      clk;
    logic                      rst_n;
    logic                      bus_req;
    bus_cmd_t                  bus_cmd;
    logic                      bus_ack;
    bus_rsp_t                  bus_rsp;
    logic [`POLARA_DATA_W-1:0] exit_val;

    logic [63:0]               l2_model [logic [31:0]];
    logic [63:0]               exit_model;
    logic [31:0]               addrs [$];
    int unsigned               errors;
    int unsigned               checks;

    polara_soc i_dut (
        .clk_i    (clk     ),
        .rst_n_i  (rst_n   ),
        .bus_req_i(bus_req ),
        .bus_cmd_i(bus_cmd ),
        .bus_ack_o(bus_ack ),
        .bus_rsp_o(bus_rsp ),
        .exit_o   (exit_val)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic log_error(input string msg);
        errors++;
        $display("** Error (%0t ns): %s", $time, msg);
    endtask

    function automatic logic addr_mapped(input logic [31:0] addr);
        return (addr >= `POLARA_L2_BASE && addr < `POLARA_L2_BASE + `POLARA_L2_BYTES) ||
               (addr >= `POLARA_CTRL_BASE && addr < `POLARA_CTRL_BASE + `POLARA_CTRL_BYTES);
    endfunction

    function automatic logic [63:0] merge_bytes(input logic [63:0] old_val,
                                                input logic [63:0] new_val,
                                                input logic [7:0]  be);
        logic [63:0] res;
        res = old_val;
        for (int i = 0; i < 8; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    ////////////////////
    // Protocol checks
    ////////////////////

    a_ack_needs_req : assert property (@(posedge clk) disable iff (!rst_n)
        $rose(bus_ack) |-> $past(bus_req))
        else log_error("ack rose without a request");

    a_ack_holds : assert property (@(posedge clk) disable iff (!rst_n)
        bus_ack && bus_req |=> bus_ack)
        else log_error("ack dropped while request still high");

    a_ack_falls : assert property (@(posedge clk) disable iff (!rst_n)
        bus_ack && !bus_req |=> !bus_ack)
        else log_error("ack did not fall one clock after request release");

    // Edge that samples req counts as the first
    a_mapped_latency : assert property (@(posedge clk) disable iff (!rst_n)
        $rose(bus_req) && addr_mapped(bus_cmd.addr) |-> !bus_ack [*3] ##1 bus_ack)
        else log_error("mapped access ack latency is not 3 clocks");

    a_unmapped_latency : assert property (@(posedge clk) disable iff (!rst_n)
        $rose(bus_req) && !addr_mapped(bus_cmd.addr) |-> !bus_ack [*2] ##1 bus_ack)
        else log_error("unmapped access ack latency is not 2 clocks");

    // One four-phase transfer started 1 ns after a rising edge
    task automatic bus_xfer(input logic we, input logic [31:0] addr,
                            input logic [63:0] wdata, input logic [7:0] be,
                            input int unsigned hold, output bus_rsp_t rsp);
        bus_cmd = '{we: we, addr: addr, wdata: wdata, be: be};
        bus_req = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!bus_ack);
        rsp = bus_rsp;
        repeat (hold) begin
            @(posedge clk);
            #1;
        end
        if (hold != 0) begin
            checks++;
            assert (bus_rsp === rsp) else log_error("response changed during ack phase");
        end
        bus_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (bus_ack);
    endtask

    task automatic check_rsp(input bus_rsp_t rsp, input logic chk_data,
                             input logic [63:0] exp_data, input logic exp_err,
                             input string what);
        checks++;
        assert (rsp.err === exp_err && (!chk_data || rsp.rdata === exp_data))
        else log_error($sformatf("%s: got data %h err %b, expected data %h err %b",
                                 what, rsp.rdata, rsp.err, exp_data, exp_err));
    endtask

    // Error accesses must leave L2 and exit untouched
    task automatic check_untouched(input logic [31:0] l2_addr);
        bus_rsp_t rsp;
        bus_xfer(1'b0, l2_addr, '0, '0, 0, rsp);
        check_rsp(rsp, 1'b1, l2_model[l2_addr], 1'b0, "L2 word after error access");
        checks++;
        assert (exit_val === exit_model)
        else log_error($sformatf("exit_o changed to %h, expected %h", exit_val, exit_model));
    endtask

    initial begin : stimulus
        bus_rsp_t    rsp;
        logic [63:0] data;
        logic [7:0]  be;
        logic [31:0] chk_addr;
        int unsigned base;
        void'($urandom(32'he8f8));
        errors   = 0;
        checks   = 0;
        rst_n    = 1'b0;
        bus_req  = 1'b0;
        bus_cmd  = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        checks++;
        assert (bus_ack === 1'b0 && exit_val === '0) else log_error("outputs not low after reset");
        exit_model = '0;

        // Groups of 8 consecutive words hit every bank
        for (int g = 0; g < N_L2 / 8; g++) begin
            base = $urandom_range(L2_WORDS - 8, 0);
            for (int w = 0; w < 8; w++) begin
                addrs.push_back(`POLARA_L2_BASE + (base + w) * 8);
            end
        end
        foreach (addrs[i]) begin
            data = {$urandom, $urandom};
            bus_xfer(1'b1, addrs[i], data, 8'hff, $urandom_range(2, 0), rsp);
            check_rsp(rsp, 1'b0, '0, 1'b0, "L2 full write");
            l2_model[addrs[i]] = data;
        end
        foreach (addrs[i]) begin
            data = {$urandom, $urandom};
            be   = $urandom_range(255, 1);
            bus_xfer(1'b1, addrs[i], data, be, $urandom_range(2, 0), rsp);
            check_rsp(rsp, 1'b0, '0, 1'b0, "L2 partial write");
            l2_model[addrs[i]] = merge_bytes(l2_model[addrs[i]], data, be);
        end
        foreach (addrs[i]) begin
            bus_xfer(1'b0, addrs[i], '0, '0, $urandom_range(2, 0), rsp);
            check_rsp(rsp, 1'b1, l2_model[addrs[i]], 1'b0, $sformatf("L2 read %h", addrs[i]));
        end

        ////////////////////
        // Control registers
        ////////////////////
        data = {$urandom, $urandom};
        bus_xfer(1'b1, `POLARA_CTRL_BASE + `POLARA_CTRL_EXIT_OFS, data, 8'hff, 1, rsp);
        check_rsp(rsp, 1'b0, '0, 1'b0, "exit write");
        exit_model = data;
        check_untouched(addrs[1]);
        data = {$urandom, $urandom};
        be   = $urandom_range(254, 1);
        bus_xfer(1'b1, `POLARA_CTRL_BASE + `POLARA_CTRL_EXIT_OFS, data, be, 0, rsp);
        exit_model = merge_bytes(exit_model, data, be);
        bus_xfer(1'b0, `POLARA_CTRL_BASE + `POLARA_CTRL_EXIT_OFS, '0, '0, 0, rsp);
        check_rsp(rsp, 1'b1, exit_model, 1'b0, "exit read back");
        bus_xfer(1'b0, `POLARA_CTRL_BASE + `POLARA_CTRL_BASE_OFS, '0, '0, 0, rsp);
        check_rsp(rsp, 1'b1, 64'h8000_0000, 1'b0, "L2 base register");
        bus_xfer(1'b0, `POLARA_CTRL_BASE + `POLARA_CTRL_END_OFS, '0, '0, 0, rsp);
        check_rsp(rsp, 1'b1, 64'h8001_0000, 1'b0, "L2 end register");

        // Unmapped write aliases the low bits of the checked word
        chk_addr = addrs[0];
        bus_xfer(1'b0, 32'hC000_0000, '0, '0, 0, rsp);
        check_rsp(rsp, 1'b1, '0, 1'b1, "unmapped read");
        check_untouched(chk_addr);
        bus_xfer(1'b1, 32'hC000_0000 | chk_addr[15:0], ~l2_model[chk_addr], 8'hff, 2, rsp);
        check_rsp(rsp, 1'b0, '0, 1'b1, "unmapped write");
        check_untouched(chk_addr);
        bus_xfer(1'b1, `POLARA_CTRL_BASE + `POLARA_CTRL_BASE_OFS, ~exit_model, 8'hff, 0, rsp);
        check_rsp(rsp, 1'b0, '0, 1'b1, "base register write");
        check_untouched(chk_addr);
        bus_xfer(1'b0, `POLARA_CTRL_BASE + 32'h18, '0, '0, 0, rsp);
        check_rsp(rsp, 1'b0, '0, 1'b1, "illegal offset read");
        check_untouched(chk_addr);
        bus_xfer(1'b1, `POLARA_CTRL_BASE + 32'h18, ~exit_model, 8'hff, 1, rsp);
        check_rsp(rsp, 1'b0, '0, 1'b1, "illegal offset write");
        check_untouched(chk_addr);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the DUT stopped answering", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule : tb_polara_soc

/* polara_soc.sv */
/*
 * Memory subsystem top. Four-phase req/ack port, one command at a time.
 */
`timescale 1ns/100ps
`include "polara_cfg.svh"

module polara_soc import polara_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      bus_req_i,
    input  bus_cmd_t                  bus_cmd_i,
    output logic                      bus_ack_o,
    output bus_rsp_t                  bus_rsp_o,
    output logic [`POLARA_DATA_W-1:0] exit_o
);

    bus_cmd_t tgt_cmd;
    logic     l2_req, l2_rvalid;
    bus_rsp_t l2_rsp;
    logic     ctrl_req, ctrl_rvalid;
    bus_rsp_t ctrl_rsp;

    soc_bus_demux i_soc_bus_demux (
        .clk_i        (clk_i      ),
        .rst_n_i      (rst_n_i    ),
        .bus_req_i    (bus_req_i  ),
        .bus_cmd_i    (bus_cmd_i  ),
        .bus_ack_o    (bus_ack_o  ),
        .bus_rsp_o    (bus_rsp_o  ),
        .tgt_cmd_o    (tgt_cmd    ),
        .l2_req_o     (l2_req     ),
        .l2_rvalid_i  (l2_rvalid  ),
        .l2_rsp_i     (l2_rsp     ),
        .ctrl_req_o   (ctrl_req   ),
        .ctrl_rvalid_i(ctrl_rvalid),
        .ctrl_rsp_i   (ctrl_rsp   )
    );

    ////////////////////
    // Targets
    ////////////////////

    l2_mem i_l2_mem (
        .clk_i   (clk_i    ),
        .rst_n_i (rst_n_i  ),
        .req_i   (l2_req   ),
        .cmd_i   (tgt_cmd  ),
        .rvalid_o(l2_rvalid),
        .rsp_o   (l2_rsp   )
    );

    ctrl_registers i_ctrl_registers (
        .clk_i   (clk_i      ),
        .rst_n_i (rst_n_i    ),
        .req_i   (ctrl_req   ),
        .cmd_i   (tgt_cmd    ),
        .rvalid_o(ctrl_rvalid),
        .rsp_o   (ctrl_rsp   ),
        .exit_o  (exit_o     )
    );

endmodule : polara_soc

/* ctrl_registers.sv */
/*
 * Exit register and L2 address info. Only aligned 64-bit offsets decode.
 * Everything else in the region answers with an error.
 */
`timescale 1ns/100ps
`include "polara_cfg.svh"

module ctrl_registers import polara_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      req_i,
    input  bus_cmd_t                  cmd_i,
    output logic                      rvalid_o,
    output bus_rsp_t                  rsp_o,
    output logic [`POLARA_DATA_W-1:0] exit_o
);

    localparam logic [`POLARA_DATA_W-1:0] L2_BASE_ADDR = `POLARA_DATA_W'(`POLARA_L2_BASE);
    localparam logic [`POLARA_DATA_W-1:0] L2_END_ADDR  =
        `POLARA_DATA_W'(`POLARA_L2_BASE) + `POLARA_DATA_W'(`POLARA_L2_BYTES);

    logic [`POLARA_ADDR_W-1:0] ofs;
    ctrl_reg_e                 reg_sel;
    logic [`POLARA_DATA_W-1:0] exit_q;
    logic                      rvalid_q;
    bus_rsp_t                  rsp_d, rsp_q;

    // Region already checked upstream
    assign ofs = cmd_i.addr - `POLARA_CTRL_BASE;

    always_comb begin
        case (ofs)
            `POLARA_CTRL_EXIT_OFS: reg_sel = REG_EXIT;
            `POLARA_CTRL_BASE_OFS: reg_sel = REG_BASE;
            `POLARA_CTRL_END_OFS:  reg_sel = REG_END;
            default:               reg_sel = REG_ILLEGAL;
        endcase
    end

    // Read-only registers reject writes
    always_comb begin
        rsp_d = '{rdata: '0, err: 1'b1};
        case (reg_sel)
            REG_EXIT: rsp_d = '{rdata: exit_q, err: 1'b0};
            REG_BASE: rsp_d = '{rdata: L2_BASE_ADDR, err: cmd_i.we};
            REG_END:  rsp_d = '{rdata: L2_END_ADDR, err: cmd_i.we};
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
            exit_q   <= '0;
        end else begin
            rvalid_q <= req_i;
            if (req_i && cmd_i.we && reg_sel == REG_EXIT) begin
                for (int i = 0; i < `POLARA_DATA_W / 8; i++) begin
                    if (cmd_i.be[i]) begin
                        exit_q[8*i +: 8] <= cmd_i.wdata[8*i +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rsp_q <= rsp_d;
        end
    end

    assign rvalid_o = rvalid_q;
    assign rsp_o    = rsp_q;
    assign exit_o   = exit_q;

    a_req_in_region : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_i |-> ofs < `POLARA_CTRL_BYTES);

endmodule : ctrl_registers

/* l2_mem.sv */
/*
 * Banked L2, word interleaved over 8 banks. No stall, read data one
 * cycle after the request. Address bits above the region are ignored.
 */
`timescale 1ns/100ps
`include "polara_cfg.svh"

module l2_mem import polara_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     req_i,
    input  bus_cmd_t cmd_i,
    output logic     rvalid_o,
    output bus_rsp_t rsp_o
);

    localparam int unsigned DATA_W     = `POLARA_DATA_W;
    localparam int unsigned NBANKS     = `POLARA_L2_BANKS;
    localparam int unsigned BANK_WORDS = `POLARA_L2_BANK_WORDS;
    localparam int unsigned OFS_W      = $clog2(DATA_W / 8);
    localparam int unsigned BANK_W     = $clog2(NBANKS);
    localparam int unsigned WORD_W     = $clog2(BANK_WORDS);

    logic [BANK_W-1:0]              bank_idx, bank_sel_q;
    logic [WORD_W-1:0]              word_idx;
    logic [NBANKS-1:0][DATA_W-1:0]  bank_rdata;
    logic                           rvalid_q;

    // Bank from the low word bits, row from the bits above
    assign bank_idx = cmd_i.addr[OFS_W +: BANK_W];
    assign word_idx = cmd_i.addr[OFS_W + BANK_W +: WORD_W];

    for (genvar b = 0; b < NBANKS; b++) begin : gen_bank
        logic [DATA_W-1:0] mem_q [BANK_WORDS];
        logic [DATA_W-1:0] rdata_q;
        logic              hit;

        assign hit = req_i && (bank_idx == BANK_W'(b));

        always_ff @(posedge clk_i) begin
            if (hit) begin
                if (cmd_i.we) begin
                    for (int i = 0; i < DATA_W / 8; i++) begin
                        if (cmd_i.be[i]) begin
                            mem_q[word_idx][8*i +: 8] <= cmd_i.wdata[8*i +: 8];
                        end
                    end
                end else begin
                    rdata_q <= mem_q[word_idx];
                end
            end
        end

        assign bank_rdata[b] = rdata_q;
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            bank_sel_q <= bank_idx;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req_i;
        end
    end

    assign rvalid_o    = rvalid_q;
    assign rsp_o.rdata = bank_rdata[bank_sel_q];
    assign rsp_o.err   = 1'b0;

    a_rvalid_follows_req : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rvalid_o |-> $past(req_i));

endmodule : l2_mem

/* soc_bus_demux.sv */
/*
 * Four-phase port to internal pulse bus. Master must hold the command while
 * req is high. Unmapped addresses are answered here, one cycle late.
 */
`timescale 1ns/100ps
`include "polara_cfg.svh"

module soc_bus_demux import polara_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     bus_req_i,
    input  bus_cmd_t bus_cmd_i,
    output logic     bus_ack_o,
    output bus_rsp_t bus_rsp_o,
    output bus_cmd_t tgt_cmd_o,
    output logic     l2_req_o,
    input  logic     l2_rvalid_i,
    input  bus_rsp_t l2_rsp_i,
    output logic     ctrl_req_o,
    input  logic     ctrl_rvalid_i,
    input  bus_rsp_t ctrl_rsp_i
);

    port_state_e state_q;
    slv_sel_e    sel_d, sel_q;
    bus_cmd_t    cmd_q;
    bus_rsp_t    rsp_q, rsp_sel;
    logic        rsp_vld;
    logic        l2_req_q, ctrl_req_q, none_vld_q, ack_q;

    function automatic logic in_region(logic [`POLARA_ADDR_W-1:0] addr,
                                       logic [`POLARA_ADDR_W-1:0] base,
                                       logic [`POLARA_ADDR_W-1:0] len);
        return (addr - base) < len;
    endfunction

    ////////////////////
    // Address decode
    ////////////////////

    always_comb begin
        if (in_region(bus_cmd_i.addr, `POLARA_L2_BASE, `POLARA_L2_BYTES)) begin
            sel_d = SLV_L2;
        end else if (in_region(bus_cmd_i.addr, `POLARA_CTRL_BASE, `POLARA_CTRL_BYTES)) begin
            sel_d = SLV_CTRL;
        end else begin
            sel_d = SLV_NONE;
        end
    end

    // Response of the selected target, error if unmapped
    always_comb begin
        rsp_vld = none_vld_q;
        rsp_sel = '{rdata: '0, err: 1'b1};
        case (sel_q)
            SLV_L2: begin
                rsp_vld = l2_rvalid_i;
                rsp_sel = l2_rsp_i;
            end
            SLV_CTRL: begin
                rsp_vld = ctrl_rvalid_i;
                rsp_sel = ctrl_rsp_i;
            end
            default: ;
        endcase
    end

    ////////////////////
    // Port FSM
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            sel_q      <= SLV_NONE;
            l2_req_q   <= 1'b0;
            ctrl_req_q <= 1'b0;
            none_vld_q <= 1'b0;
            ack_q      <= 1'b0;
        end else begin
            l2_req_q   <= 1'b0;
            ctrl_req_q <= 1'b0;
            none_vld_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (bus_req_i) begin
                        sel_q      <= sel_d;
                        l2_req_q   <= (sel_d == SLV_L2);
                        ctrl_req_q <= (sel_d == SLV_CTRL);
                        none_vld_q <= (sel_d == SLV_NONE);
                        state_q    <= WAIT_RSP;
                    end
                end
                WAIT_RSP: begin
                    if (rsp_vld) begin
                        state_q <= ACK;
                        ack_q   <= 1'b1;
                    end
                end
                ACK: begin
                    // Hold until the master releases req
                    if (!bus_req_i) begin
                        state_q <= IDLE;
                        ack_q   <= 1'b0;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && bus_req_i) begin
            cmd_q <= bus_cmd_i;
        end
        if (state_q == WAIT_RSP && rsp_vld) begin
            rsp_q <= rsp_sel;
        end
    end

    assign tgt_cmd_o  = cmd_q;
    assign l2_req_o   = l2_req_q;
    assign ctrl_req_o = ctrl_req_q;
    assign bus_ack_o  = ack_q;
    assign bus_rsp_o  = rsp_q;

    a_rvalid_in_wait : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (l2_rvalid_i || ctrl_rvalid_i) |-> state_q == WAIT_RSP);

    a_no_ack_in_idle : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        state_q == IDLE |-> !bus_ack_o);

endmodule : soc_bus_demux

/* polara_pkg.sv */
/*
 * Bus types shared by all blocks. Single outstanding command,
 * no IDs, no bursts.
 */
`include "polara_cfg.svh"

package polara_pkg;

    typedef struct packed {
        logic                        we;
        logic [`POLARA_ADDR_W-1:0]   addr;
        logic [`POLARA_DATA_W-1:0]   wdata;
        logic [`POLARA_DATA_W/8-1:0] be;
    } bus_cmd_t;

    typedef struct packed {
        logic [`POLARA_DATA_W-1:0] rdata;
        logic                      err;
    } bus_rsp_t;

    // Decode targets
    typedef enum logic [1:0] {
        SLV_L2,
        SLV_CTRL,
        SLV_NONE
    } slv_sel_e;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_RSP,
        ACK
    } port_state_e;

    typedef enum logic [1:0] {
        REG_EXIT,
        REG_BASE,
        REG_END,
        REG_ILLEGAL
    } ctrl_reg_e;

endpackage : polara_pkg

/* polara_cfg.svh */
/*
 * Sizes and memory map. L2 bytes must equal banks * bank words * 8,
 * and both regions must not overlap.
 */
`ifndef POLARA_CFG_SVH
`define POLARA_CFG_SVH

// Bus widths
`define POLARA_DATA_W 64
`define POLARA_ADDR_W 32

// L2 geometry
`define POLARA_L2_BANKS      8
`define POLARA_L2_BANK_WORDS 1024

// Memory map
`define POLARA_L2_BASE    32'h8000_0000
`define POLARA_L2_BYTES   32'h0001_0000
`define POLARA_CTRL_BASE  32'hD000_0000
`define POLARA_CTRL_BYTES 32'h0000_1000

// Control register byte offsets
`define POLARA_CTRL_EXIT_OFS 32'h0000_0000
`define POLARA_CTRL_BASE_OFS 32'h0000_0008
`define POLARA_CTRL_END_OFS  32'h0000_0010

`endif
